//--- rv_core.f
rv_isa_pkg.sv
rv_bus_pkg.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_retire_counter.sv
rv_control.sv
rv_core.sv
tb_rv_checker.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;

	localparam bus_addr_t RESET_PC = 32'h0000_0000;
	localparam int MEM_WORDS = 1024;
	localparam int RUN_INSTRS = 48;   // both programs, loop passes included.
	localparam int WORST_CPI = 16;   // two accesses at three wait states, plus exec and wb.
	localparam int MAX_CYCLES = RUN_INSTRS * WORST_CPI + 200;

	logic clock = 1'b0;
	logic arst_n;
	logic cyc;
	logic stb;
	logic we;
	bus_addr_t adr;
	bus_data_t dat_w;
	bus_sel_t sel;
	bus_data_t dat_r;
	logic ack;
	logic err;
	logic halted;
	int error_count;
	int check_count;
	int cycle_count = 0;
	int waits_left = -1;
	word_t rng;
	word_t mem [MEM_WORDS];

	always #50 clock = ~clock;

	rv_core #(.RESET_PC(RESET_PC)) dut_i (
		.clock(clock), .arst_n(arst_n),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
		.dat_r(dat_r), .ack(ack), .err(err), .halted(halted)
	);

	tb_rv_checker #(.RESET_PC(RESET_PC), .MEM_WORDS(MEM_WORDS)) checker_i (
		.clock(clock), .arst_n(arst_n),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
		.ack(ack), .err(err), .halted(halted),
		.error_count(error_count), .check_count(check_count)
	);

	function automatic word_t xorshift(word_t s);
		word_t x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t asm_u(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic word_t asm_i(opcode_t op, logic [2:0] f3, logic [4:0] rd,
		logic [4:0] rs1, int imm);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic word_t asm_r(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
		logic [4:0] rs2);
		return {f7, rs2, rs1, 3'b000, rd, OP_REG};
	endfunction

	function automatic word_t asm_sw(logic [4:0] rs2, logic [4:0] rs1, int imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t asm_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, int off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t asm_jal(logic [4:0] rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	task automatic put_word(int idx, word_t w);
		mem[idx] = w;
		checker_i.image[idx] = w;
	endtask

	// random fill everywhere, then the program from RESET_PC.
	task automatic load_image(int run);
		for (int i = 0; i < MEM_WORDS; i++) begin
			rng = xorshift(rng);
			put_word(i, rng ^ (i * 4));
		end
		if (run == 0) begin
			put_word(0, asm_u(1, 20'h12345));
			put_word(1, asm_i(OP_IMM, 3'b000, 3, 0, 32'h600));   // store area.
			put_word(2, asm_i(OP_IMM, 3'b000, 2, 0, 32'h400));   // random data area.
			put_word(3, asm_i(OP_IMM, 3'b000, 4, 1, -5));
			put_word(4, asm_r(7'h00, 5, 1, 4));
			put_word(5, asm_r(7'h20, 6, 4, 1));
			put_word(6, asm_r(7'h00, 0, 1, 1));
			put_word(7, asm_i(OP_IMM, 3'b000, 0, 1, 7));
			put_word(8, asm_i(OP_IMM, 3'b000, 9, 0, 16));
			put_word(9, asm_sw(5, 3, 0));
			put_word(10, asm_sw(6, 3, 4));
			put_word(11, asm_sw(0, 3, 8));
			put_word(12, asm_i(OP_LOAD, 3'b010, 7, 2, 0));
			put_word(13, asm_i(OP_LOAD, 3'b010, 8, 2, 12));
			put_word(14, asm_sw(7, 3, 12));
			put_word(15, asm_sw(8, 3, 16));
			put_word(16, asm_b(3'b000, 7, 7, 8));   // taken beq.
			put_word(17, asm_i(OP_IMM, 3'b000, 9, 9, 1));
			put_word(18, asm_b(3'b001, 7, 7, 8));
			put_word(19, asm_i(OP_IMM, 3'b000, 9, 9, 2));
			put_word(20, asm_b(3'b000, 0, 5, 8));
			put_word(21, asm_i(OP_IMM, 3'b000, 9, 9, 4));
			put_word(22, asm_b(3'b001, 5, 6, 8));   // taken bne.
			put_word(23, asm_i(OP_IMM, 3'b000, 9, 9, 8));
			put_word(24, asm_sw(9, 3, 20));
			put_word(25, asm_jal(10, 8));
			put_word(26, asm_i(OP_IMM, 3'b000, 9, 0, 99));
			put_word(27, asm_sw(10, 3, 24));
			put_word(28, asm_u(11, COUNTER_ADDR[31:12]));
			put_word(29, asm_i(OP_LOAD, 3'b010, 12, 11, 0));
			put_word(30, asm_sw(12, 3, 28));
			put_word(31, asm_sw(9, 3, 32));
			put_word(32, asm_i(OP_IMM, 3'b000, 13, 0, 3));
			put_word(33, asm_i(OP_IMM, 3'b000, 14, 0, 1));
			put_word(34, asm_r(7'h00, 14, 14, 14));
			put_word(35, asm_i(OP_IMM, 3'b000, 13, 13, -1));
			put_word(36, asm_b(3'b001, 13, 0, -8));   // backward loop.
			put_word(37, asm_sw(14, 3, 36));
			put_word(38, asm_i(OP_LOAD, 3'b010, 15, 11, 0));
			put_word(39, asm_sw(15, 3, 40));
			put_word(40, 32'h0000_0073);   // ecall.
			put_word(41, asm_sw(1, 3, 44));
		end else begin
			put_word(0, asm_i(OP_IMM, 3'b000, 1, 0, 32'h123));
			put_word(1, asm_i(OP_IMM, 3'b000, 3, 0, 32'h700));
			put_word(2, asm_sw(1, 3, 0));
			put_word(3, asm_jal(0, 32'h2000));   // lands beyond the memory.
			put_word(4, asm_sw(1, 3, 4));
		end
	endtask

	// wishbone slave with zero to three wait states.
	always @(posedge clock) begin
		if (ack || err || !(cyc && stb)) begin
			#1;
			ack = 1'b0;
			err = 1'b0;
			waits_left = -1;
		end else begin
			if (waits_left < 0) begin
				rng = xorshift(rng);
				waits_left = rng % 4;
			end
			#1;
			if (waits_left > 0) begin
				waits_left--;
			end else if (adr >= MEM_WORDS * 4) begin
				err = 1'b1;
			end else begin
				ack = 1'b1;
				if (we) begin
					mem[adr / 4] = dat_w;
				end else begin
					dat_r = mem[adr / 4];
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("timeout after %0d cycles, the core did not halt", cycle_count);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic run_program(int run);
		@(posedge clock);
		#1;
		arst_n = 1'b0;
		load_image(run);
		repeat (3) @(posedge clock);
		#1;
		arst_n = 1'b1;
		while (!halted) begin
			@(posedge clock);
		end
		repeat (8) @(posedge clock);   // watch for stray bus cycles.
	endtask

	initial begin
		arst_n = 1'b0;
		ack = 1'b0;
		err = 1'b0;
		dat_r = '0;
		rng = 32'hfc11;
		run_program(0);
		run_program(1);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_rv_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_checker #(
	parameter rv_bus_pkg::bus_addr_t RESET_PC = 32'h0000_0000,
	parameter int MEM_WORDS = 1024
) (
	input logic clock,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input rv_bus_pkg::bus_addr_t adr,
	input rv_bus_pkg::bus_data_t dat_w,
	input rv_bus_pkg::bus_sel_t sel,
	input logic ack,
	input logic err,
	input logic halted,
	output int error_count,
	output int check_count
);
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;

	localparam int STEP_LIMIT = 200;   // longest run of instructions between two stores.

	word_t image [MEM_WORDS];
	word_t regs_m [16];
	bus_addr_t pc_m;
	word_t retired_m;
	logic prev_cyc;
	logic prev_end;
	logic prev_halted;

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// one instruction of the model. 1 is a store, 2 a halt, 0 anything else.
	function automatic int step_model(output word_t st_addr, output word_t st_data);
		word_t ins;
		word_t a;
		word_t b;
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		word_t imm_j;
		word_t ea;
		word_t result;
		bus_addr_t pc_next;
		logic write_rd;
		int kind;
		st_addr = '0;
		st_data = '0;
		if (pc_m >= MEM_WORDS * 4) begin
			return 2;   // fetch ends in a bus error.
		end
		ins = image[pc_m / 4];
		a = regs_m[ins[18:15]];
		b = regs_m[ins[23:20]];
		imm_i = $signed(ins[31:20]);
		imm_s = $signed({ins[31:25], ins[11:7]});
		imm_b = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
		imm_j = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
		result = '0;
		write_rd = 1'b1;
		kind = 0;
		pc_next = pc_m + 4;
		case (ins[6:0])
			7'h37: result = {ins[31:12], 12'h000};
			7'h13: result = a + imm_i;
			7'h33: result = ins[30] ? a - b : a + b;
			7'h03: begin
				ea = a + imm_i;
				if (ea == COUNTER_ADDR) begin
					result = retired_m;
				end else if (ea >= MEM_WORDS * 4) begin
					return 2;
				end else begin
					result = image[ea / 4];
				end
			end
			7'h23: begin
				ea = a + imm_s;
				if (ea >= MEM_WORDS * 4) begin
					return 2;
				end
				image[ea / 4] = b;
				st_addr = ea;
				st_data = b;
				kind = 1;
				write_rd = 1'b0;
			end
			7'h63: begin
				write_rd = 1'b0;
				if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
					pc_next = pc_m + imm_b;
				end
			end
			7'h6f: begin
				result = pc_m + 4;
				pc_next = pc_m + imm_j;
			end
			default: return 2;   // ecall, or an opcode outside the subset.
		endcase
		if (write_rd) begin
			regs_m[ins[10:7]] = result;   // programs only name x0 to x15.
		end
		regs_m[0] = '0;
		pc_m = pc_next;
		retired_m = retired_m + 1;
		return kind;
	endfunction

	task automatic next_event(output int kind, output word_t ev_addr, output word_t ev_data);
		int steps;
		kind = 0;
		steps = 0;
		while (kind == 0 && steps < STEP_LIMIT) begin
			kind = step_model(ev_addr, ev_data);
			steps++;
		end
	endtask

	always @(posedge clock or negedge arst_n) begin : watch_bus
		int kind;
		word_t exp_addr;
		word_t exp_data;
		if (!arst_n) begin
			pc_m = RESET_PC;
			retired_m = '0;
			for (int i = 0; i < 16; i++) begin
				regs_m[i] = '0;
			end
			prev_cyc = 1'b0;
			prev_end = 1'b0;
			prev_halted = 1'b0;
		end else begin
			if (cyc && stb && we && ack) begin
				next_event(kind, exp_addr, exp_data);
				check_count++;
				if (kind != 1) begin
					error_count++;
					$display("%0t: write to %h acknowledged but the model has no store left",
						$time, adr);
				end else begin
					if (adr !== exp_addr) begin
						error_count++;
						$display("[FAIL] %0t adr: got %h, expected %h", $time, adr, exp_addr);
					end
					if (dat_w !== exp_data) begin
						error_count++;
						$display("[FAIL] %0t dat_w: got %h, expected %h", $time, dat_w, exp_data);
					end
				end
			end
			if (cyc && sel !== 4'hf) begin
				error_count++;
				$display("[FAIL] %0t sel: got %h, expected %h", $time, sel, 4'hf);
			end
			if (halted && !prev_halted) begin
				next_event(kind, exp_addr, exp_data);
				check_count++;
				if (kind != 2) begin
					error_count++;
					$display("%0t: halted rose but the model still stores to %h", $time, exp_addr);
				end
			end
			if (prev_halted && !halted) begin
				error_count++;
				$display("%0t: halted fell without a reset", $time);
			end
			if (cyc !== stb) begin
				error_count++;
				$display("%0t: stb does not follow cyc", $time);
			end
			if (prev_cyc && !prev_end && !cyc) begin
				error_count++;
				$display("%0t: cyc dropped before ack or err", $time);
			end
			if (prev_halted && cyc && !prev_cyc) begin
				error_count++;
				$display("%0t: a bus cycle started after halt", $time);
			end
			prev_cyc = cyc;
			prev_end = ack || err;
			prev_halted = halted;
		end
	end

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
	parameter rv_bus_pkg::bus_addr_t RESET_PC = 32'h0000_0000
) (
	input logic clock,
	input logic arst_n,
	output logic cyc,
	output logic stb,
	output logic we,
	output rv_bus_pkg::bus_addr_t adr,
	output rv_bus_pkg::bus_data_t dat_w,
	output rv_bus_pkg::bus_sel_t sel,
	input rv_bus_pkg::bus_data_t dat_r,
	input logic ack,
	input logic err,
	output logic halted
);
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;

	word_t instr;
	bus_addr_t pc;
	bus_addr_t next_pc;
	bus_addr_t exec_addr;
	logic is_load;
	logic is_store;
	logic is_ecall;
	word_t load_data;
	logic rf_wen_en;
	logic retire;
	logic mem_req;
	logic mem_we;
	bus_addr_t mem_addr;
	logic mem_done;
	logic mem_err;
	word_t mem_rdata;
	reg_idx_t raddr_a;
	reg_idx_t raddr_b;
	reg_idx_t waddr;
	word_t rs_a;
	word_t rs_b;
	logic rd_wen;
	word_t rd_data;
	word_t store_data;
	word_t count;
	logic rf_wen;

	assign rf_wen = rf_wen_en && rd_wen;   // write only in WB, and only if the op has rd.

	rv_control #(.RESET_PC(RESET_PC)) control_i (
		.clock(clock), .arst_n(arst_n),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_done(mem_done), .mem_err(mem_err), .mem_rdata(mem_rdata),
		.instr(instr), .pc(pc), .next_pc(next_pc), .exec_addr(exec_addr),
		.is_load(is_load), .is_store(is_store), .is_ecall(is_ecall),
		.load_data(load_data), .rf_wen_en(rf_wen_en), .retire(retire), .halted(halted)
	);

	rv_execute execute_i (
		.instr(instr), .pc(pc), .rs_a(rs_a), .rs_b(rs_b), .load_data(load_data),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .waddr(waddr),
		.rd_wen(rd_wen), .rd_data(rd_data), .mem_addr(exec_addr), .store_data(store_data),
		.next_pc(next_pc), .is_load(is_load), .is_store(is_store), .is_ecall(is_ecall)
	);

	rv_regfile regfile_i (
		.clock(clock), .raddr_a(raddr_a), .raddr_b(raddr_b),
		.rdata_a(rs_a), .rdata_b(rs_b),
		.wen(rf_wen), .waddr(waddr), .wdata(rd_data)
	);

	rv_lsu lsu_i (
		.clock(clock), .arst_n(arst_n),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(store_data),
		.mem_done(mem_done), .mem_err(mem_err), .mem_rdata(mem_rdata), .count(count),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
		.dat_r(dat_r), .ack(ack), .err(err)
	);

	rv_retire_counter counter_i (
		.clock(clock), .arst_n(arst_n), .retire(retire), .count(count)
	);

endmodule

`default_nettype wire

//--- rv_control.sv
`timescale 1ns/1ns
`default_nettype none

module rv_control #(
	parameter rv_bus_pkg::bus_addr_t RESET_PC = 32'h0000_0000
) (
	input logic clock,
	input logic arst_n,
	output logic mem_req,
	output logic mem_we,
	output rv_bus_pkg::bus_addr_t mem_addr,
	input logic mem_done,
	input logic mem_err,
	input rv_isa_pkg::word_t mem_rdata,
	output rv_isa_pkg::word_t instr,
	output rv_bus_pkg::bus_addr_t pc,
	input rv_bus_pkg::bus_addr_t next_pc,
	input rv_bus_pkg::bus_addr_t exec_addr,
	input logic is_load,
	input logic is_store,
	input logic is_ecall,
	output rv_isa_pkg::word_t load_data,
	output logic rf_wen_en,
	output logic retire,
	output logic halted
);

	typedef enum logic [2:0] {
		FETCH,
		EXEC,
		MEM,
		WB,
		HALT
	} ctrl_state_t;

	ctrl_state_t state;
	logic waiting;   // request issued, mem_done not yet seen.

	assign mem_req = (state == FETCH || state == MEM) && !waiting;
	assign mem_we = (state == MEM) && is_store;
	assign mem_addr = (state == FETCH) ? pc : exec_addr;
	assign rf_wen_en = (state == WB);
	assign retire = (state == WB);
	assign halted = (state == HALT);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH;
			waiting <= 1'b0;
			pc <= RESET_PC;
		end else begin
			if (mem_req) begin
				waiting <= 1'b1;
			end else if (mem_done) begin
				waiting <= 1'b0;
			end
			case (state)
				FETCH: if (mem_done) state <= mem_err ? HALT : EXEC;
				EXEC: begin
					if (is_ecall) begin
						state <= HALT;
					end else begin
						state <= (is_load || is_store) ? MEM : WB;
					end
				end
				MEM: if (mem_done) state <= mem_err ? HALT : WB;
				WB: begin
					pc <= next_pc;
					state <= FETCH;
				end
				default: state <= HALT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == FETCH && mem_done) instr <= mem_rdata;
		if (state == MEM && mem_done) load_data <= mem_rdata;
	end

	// only reset brings the core back out of HALT.
	a_halt_sticky: assert property (@(posedge clock) disable iff (!arst_n)
		state == HALT |=> state == HALT);

endmodule

`default_nettype wire

//--- rv_retire_counter.sv
`timescale 1ns/1ns
`default_nettype none

module rv_retire_counter (
	input logic clock,
	input logic arst_n,
	input logic retire,
	output rv_isa_pkg::word_t count
);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (retire) begin
			count <= count + 32'd1;   // wraps after 2^32 instructions.
		end
	end

endmodule

`default_nettype wire

//--- rv_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
	input logic clock,
	input logic arst_n,
	input logic mem_req,
	input logic mem_we,
	input rv_bus_pkg::bus_addr_t mem_addr,
	input rv_isa_pkg::word_t mem_wdata,
	output logic mem_done,
	output logic mem_err,
	output rv_isa_pkg::word_t mem_rdata,
	input rv_isa_pkg::word_t count,
	output logic cyc,
	output logic stb,
	output logic we,
	output rv_bus_pkg::bus_addr_t adr,
	output rv_bus_pkg::bus_data_t dat_w,
	output rv_bus_pkg::bus_sel_t sel,
	input rv_bus_pkg::bus_data_t dat_r,
	input logic ack,
	input logic err
);
	import rv_bus_pkg::*;

	logic local_hit;
	logic bus_start;
	logic bus_end;

	assign local_hit = mem_req && !mem_we && (mem_addr == COUNTER_ADDR);
	assign bus_start = mem_req && !local_hit;
	assign bus_end = cyc && (ack || err);
	assign sel = '1;   // word accesses only.

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			cyc <= 1'b0;
			stb <= 1'b0;
			we <= 1'b0;
			mem_done <= 1'b0;
			mem_err <= 1'b0;
		end else begin
			mem_done <= bus_end || local_hit;
			mem_err <= bus_end && err;
			if (bus_end) begin
				cyc <= 1'b0;
				stb <= 1'b0;
				we <= 1'b0;
			end else if (bus_start) begin
				cyc <= 1'b1;
				stb <= 1'b1;
				we <= mem_we;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (bus_start) begin
			adr <= mem_addr;
			dat_w <= mem_wdata;
		end
		if (local_hit) begin
			mem_rdata <= count;   // counter read never reaches the bus.
		end else if (bus_end) begin
			mem_rdata <= dat_r;
		end
	end

	// control must wait for mem_done before the next request.
	a_req_idle: assert property (@(posedge clock) disable iff (!arst_n) mem_req |-> !cyc);

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
	input rv_isa_pkg::word_t instr,
	input rv_bus_pkg::bus_addr_t pc,
	input rv_isa_pkg::word_t rs_a,
	input rv_isa_pkg::word_t rs_b,
	input rv_isa_pkg::word_t load_data,
	output rv_isa_pkg::reg_idx_t raddr_a,
	output rv_isa_pkg::reg_idx_t raddr_b,
	output rv_isa_pkg::reg_idx_t waddr,
	output logic rd_wen,
	output rv_isa_pkg::word_t rd_data,
	output rv_bus_pkg::bus_addr_t mem_addr,
	output rv_isa_pkg::word_t store_data,
	output rv_bus_pkg::bus_addr_t next_pc,
	output logic is_load,
	output logic is_store,
	output logic is_ecall
);
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;

	opcode_t opcode;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	alu_op_t alu_op;
	word_t operand_b;
	word_t alu_result;
	bus_addr_t pc_plus4;
	logic branch_taken;
	logic is_jal;

	assign opcode = instr[6:0];
	assign raddr_a = instr[18:15];
	assign raddr_b = instr[23:20];
	assign waddr = instr[10:7];   // rv32e drops the top bit of rd.

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	assign pc_plus4 = pc + 32'd4;
	assign branch_taken = instr[12] ? (rs_a != rs_b) : (rs_a == rs_b);   // funct3 bit 0 is bne.

	always_comb begin
		alu_op = ALU_ADD;
		operand_b = rs_b;
		rd_wen = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_ecall = 1'b0;
		is_jal = 1'b0;
		next_pc = pc_plus4;
		case (opcode)
			OP_LUI: begin
				alu_op = ALU_PASS_B;
				operand_b = imm_u;
				rd_wen = 1'b1;
			end
			OP_IMM: begin
				operand_b = imm_i;
				rd_wen = 1'b1;
			end
			OP_REG: begin
				alu_op = instr[30] ? ALU_SUB : ALU_ADD;
				rd_wen = 1'b1;
			end
			OP_LOAD: begin
				is_load = 1'b1;
				rd_wen = 1'b1;
			end
			OP_STORE: is_store = 1'b1;
			OP_BRANCH: begin
				if (branch_taken) begin
					next_pc = pc + imm_b;
				end
			end
			OP_JAL: begin
				is_jal = 1'b1;
				rd_wen = 1'b1;
				next_pc = pc + imm_j;
			end
			default: is_ecall = 1'b1;   // ecall, and anything unknown, stops the core.
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_SUB: alu_result = rs_a - operand_b;
			ALU_PASS_B: alu_result = operand_b;
			default: alu_result = rs_a + operand_b;
		endcase
	end

	assign rd_data = is_load ? load_data : (is_jal ? pc_plus4 : alu_result);
	assign mem_addr = rs_a + (is_store ? imm_s : imm_i);
	assign store_data = rs_b;

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
	input logic clock,
	input rv_isa_pkg::reg_idx_t raddr_a,
	input rv_isa_pkg::reg_idx_t raddr_b,
	output rv_isa_pkg::word_t rdata_a,
	output rv_isa_pkg::word_t rdata_b,
	input logic wen,
	input rv_isa_pkg::reg_idx_t waddr,
	input rv_isa_pkg::word_t wdata
);
	import rv_isa_pkg::*;

	word_t regs [16];

	assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];   // x0 reads as zero.
	assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

	always_ff @(posedge clock) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// the decoder must hand over one of the sixteen indices on a write.
	a_waddr_known: assert property (@(posedge clock) wen |-> !$isunknown(waddr));

endmodule

`default_nettype wire

//--- rv_bus_pkg.sv
`default_nettype none

package rv_bus_pkg;

	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [3:0] bus_sel_t;

	// retired-instruction counter, reachable with lui alone.
	localparam bus_addr_t COUNTER_ADDR = 32'h0002_0000;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;   // rv32e has sixteen registers.
	typedef logic [6:0] opcode_t;

	// major opcodes of the supported subset.
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_IMM = 7'b0010011;
	localparam opcode_t OP_REG = 7'b0110011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_B   // lui result goes straight through.
	} alu_op_t;

endpackage

`default_nettype wire
